// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= fetch_tb
FLIST ?= flist.f
LOG ?= sim.log
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# The log decides the result, since the run itself ends with status zero.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "ALL CHECKS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== bench/fetch_checker.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "fetch_settings.svh"

module fetch_checker (
	input  wire        clock,
	input  wire        arst_n,
	input  wire        fetch_start,
	input  wire        invalidate,
	input  wire [31:0] pc,
	input  wire [31:0] inst,
	input  wire        inst_valid,
	input  wire        inst_error,
	input  wire [31:0] araddr,
	input  wire        arvalid,
	input  wire        arready,
	input  wire [1:0]  arburst,
	input  wire [3:0]  arlen,
	input  wire        test_done,
	input  wire [2:0]  test_num,
	output int         check_count,
	output int         error_count
);
	localparam int IDX_LSB = 2 + $clog2(`LINE_WORDS);
	localparam int TAG_LSB = IDX_LSB + $clog2(`ICACHE_LINES);
	// Start edge to the edge that samples inst_valid, LOOKUP then DONE.
	localparam int HIT_LATENCY = 3;

	logic [31:0] tag_tab [`ICACHE_LINES];
	logic        valid_tab [`ICACHE_LINES];
	logic [31:0] exp_pc, exp_word;
	logic        pending, exp_cached, exp_hit, exp_err;
	int          exp_idx, lat, reqs, test_checks, test_errors;

	// Same mixing as the memory model in the bench.
	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		logic [31:0] w;
		w = {2'b00, addr[31:2]};
		return (w * 32'h9e37_79b1) ^ {w[15:0], w[31:16]} ^ 32'h0bad_f00d;
	endfunction

	// Error flag and instruction word that one PC should return.
	function automatic logic [32:0] reference_result(input logic [31:0] addr);
		logic err;
		err = addr >= 32'ha100_0000 && addr < 32'ha100_1000;
		return {err, mem_word(addr)};
	endfunction

	function automatic string test_name(input logic [2:0] n);
		case (n)
			3'd1: return "cold miss then hit";
			3'd2: return "critical word";
			3'd3: return "uncached";
			3'd4: return "conflict and invalidate";
			3'd5: return "bus error";
			default: return "back-pressure";
		endcase
	endfunction

	task automatic report_problem(input string what);
		$display("Error at %0t: %s.", $time, what);
		error_count++;
		test_errors++;
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		check_count++;
		test_checks++;
		if (expected !== actual) begin
			$display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
			error_count++;
			test_errors++;
		end
	endtask

	always @(posedge clock) begin
		if (!arst_n) begin
			pending = 1'b0;
			check_count = 0;
			error_count = 0;
			test_checks = 0;
			test_errors = 0;
			for (int i = 0; i < `ICACHE_LINES; i++) begin
				valid_tab[i] = 1'b0;
			end
		end else begin
			if (pending) begin
				lat++;
			end
			if (arvalid && arready) begin
				reqs++;
				if (!pending) begin
					report_problem("bus request with no fetch outstanding");
				end else begin
					check_value("araddr", exp_cached ?
						exp_pc & ~32'(`LINE_WORDS * 4 - 1) : exp_pc, araddr);
					check_value("arlen", exp_cached ? `LINE_WORDS - 1 : 0, 32'(arlen));
					check_value("arburst", exp_cached ? 1 : 0, 32'(arburst));
				end
			end
			if (inst_valid && !pending) begin
				report_problem("inst_valid with no fetch outstanding");
			end else if (inst_valid) begin
				check_value("inst_error", 32'(exp_err), 32'(inst_error));
				if (!exp_err) begin
					check_value("inst", exp_word, inst);
				end
				check_value("bus requests", exp_hit ? 0 : 1, reqs);
				if (exp_hit) begin
					check_value("inst_valid latency", HIT_LATENCY, lat);
				end else if (lat <= HIT_LATENCY) begin
					report_problem("a fetch that should miss returned as fast as a hit");
				end
				// A failed refill leaves the line invalid.
				if (exp_cached) begin
					valid_tab[exp_idx] = !exp_err;
					tag_tab[exp_idx] = exp_pc >> TAG_LSB;
				end
				pending = 1'b0;
			end
			if (invalidate) begin
				for (int i = 0; i < `ICACHE_LINES; i++) begin
					valid_tab[i] = 1'b0;
				end
			end
			if (fetch_start) begin
				exp_pc = pc;
				{exp_err, exp_word} = reference_result(pc);
				exp_cached = pc >= `SDRAM_BASE && pc < `SDRAM_LIMIT;
				exp_idx = int'(pc[IDX_LSB +: $clog2(`ICACHE_LINES)]);
				exp_hit = exp_cached && valid_tab[exp_idx] &&
					tag_tab[exp_idx] == (pc >> TAG_LSB);
				pending = 1'b1;
				lat = 0;
				reqs = 0;
			end
			if (test_done) begin
				$display("Test %0d, %s: %0d checks, %0d errors", test_num,
					test_name(test_num), test_checks, test_errors);
				test_checks = 0;
				test_errors = 0;
			end
		end
	end

endmodule

`default_nettype wire

// ==== bench/fetch_tb.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "fetch_settings.svh"

module fetch_tb;
	localparam int RESET_CYCLES = 16;
	localparam int RANDOM_FETCHES = 40;
	// Directed fetches of tests one to five, then the random ones.
	localparam int PLANNED_FETCHES = 39 + RANDOM_FETCHES;
	localparam int CYCLE_LIMIT = 64 * PLANNED_FETCHES + RESET_CYCLES;
	localparam logic [31:0] SEED = 32'h1c14_d82b;

	logic        clock, arst_n, fetch_start, invalidate;
	logic [31:0] pc, inst, araddr, rdata;
	logic        inst_valid, inst_error, arvalid, arready, rvalid;
	logic [1:0]  arburst, rresp;
	logic [3:0]  arlen;
	logic        test_done, stall_en;
	logic [2:0]  test_num;
	logic [31:0] pc_lfsr, bus_lfsr;
	int          check_count, error_count, cycles;

	fetch_unit dut_i (.*);
	fetch_checker checker_i (.*);

	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		logic [31:0] w;
		w = {2'b00, addr[31:2]};
		return (w * 32'h9e37_79b1) ^ {w[15:0], w[31:16]} ^ 32'h0bad_f00d;
	endfunction

	// Galois LFSR, one step for each bit taken.
	function automatic logic [31:0] take_bits(inout logic [31:0] state, input int count);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			bits = {bits[30:0], state[0]};
			state = state[0] ? (state >> 1) ^ 32'h8020_0003 : state >> 1;
		end
		return bits;
	endfunction

	// Called on a falling edge, returns on the falling edge that sees inst_valid.
	task automatic run_fetch(input logic [31:0] addr);
		fetch_start = 1'b1;
		pc = addr;
		@(negedge clock);
		fetch_start = 1'b0;
		while (!inst_valid) begin
			@(negedge clock);
		end
	endtask

	task automatic pulse_invalidate();
		invalidate = 1'b1;
		@(negedge clock);
		invalidate = 1'b0;
	endtask

	task automatic end_test(input logic [2:0] n);
		test_num = n;
		test_done = 1'b1;
		@(negedge clock);
		test_done = 1'b0;
	endtask

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	initial begin
		cycles = 0;
		while (cycles < CYCLE_LIMIT) begin
			@(posedge clock);
			cycles++;
		end
		$display("Timeout: the run did not finish within %0d cycles.", CYCLE_LIMIT);
		$display("CHECKS FAILED");
		$finish;
	end

	// Memory model. Error page bursts answer SLVERR on every beat.
	initial begin : bus_model
		logic [31:0] addr;
		logic [3:0]  len;
		int          delay;
		arready = 1'b0;
		rvalid = 1'b0;
		rdata = '0;
		rresp = 2'b00;
		bus_lfsr = SEED;
		forever begin
			@(negedge clock);
			if (arvalid) begin
				delay = stall_en ? int'(take_bits(bus_lfsr, 2)) : 0;
				repeat (delay) @(negedge clock);
				addr = araddr;
				len = arlen;
				arready = 1'b1;
				@(negedge clock);
				arready = 1'b0;
				for (int beat = 0; beat <= int'(len); beat++) begin
					if (stall_en && take_bits(bus_lfsr, 1) != 0) begin
						rvalid = 1'b0;
						@(negedge clock);
					end
					rvalid = 1'b1;
					rdata = mem_word(addr + 32'(beat) * 4);
					rresp = addr >= 32'ha100_0000 && addr < 32'ha100_1000 ? 2'b10 : 2'b00;
					@(negedge clock);
				end
				rvalid = 1'b0;
			end
		end
	end

	initial begin : stimulus
		logic [31:0] r;
		logic [31:0] base;
		fetch_start = 1'b0;
		pc = '0;
		invalidate = 1'b0;
		test_done = 1'b0;
		test_num = '0;
		stall_en = 1'b0;
		pc_lfsr = SEED;
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(negedge clock);
		arst_n = 1'b1;
		@(negedge clock);

		run_fetch(32'ha000_0100);
		run_fetch(32'ha000_010c);
		run_fetch(32'ha000_2340);
		run_fetch(32'ha000_2344);
		end_test(3'd1);

		// Each line is entered at a different word offset.
		for (int line = 0; line < 4; line++) begin
			base = 32'ha001_0000 + 32'(line) * 32'h40;
			for (int k = 0; k < 4; k++) begin
				run_fetch(base + 32'((line + k) % 4) * 4);
			end
		end
		end_test(3'd2);

		run_fetch(32'h0000_1230);
		run_fetch(32'h0000_1230);
		run_fetch(32'h8000_0040);
		run_fetch(32'h8000_0040);
		run_fetch(`SDRAM_LIMIT);
		run_fetch(`SDRAM_LIMIT);
		run_fetch(`SDRAM_BASE - 4);
		run_fetch(`SDRAM_BASE - 4);
		end_test(3'd3);

		// Same line index, different tags.
		run_fetch(32'ha000_3050);
		run_fetch(32'ha000_4050);
		run_fetch(32'ha000_3050);
		run_fetch(32'ha000_4050);
		run_fetch(32'ha000_3050);
		run_fetch(32'ha000_3054);
		pulse_invalidate();
		run_fetch(32'ha000_3050);
		end_test(3'd4);

		run_fetch(32'ha100_0200);
		run_fetch(32'ha100_0200);
		run_fetch(32'ha100_0ffc);
		run_fetch(32'ha100_1000);
		end_test(3'd5);

		stall_en = 1'b1;
		for (int i = 0; i < RANDOM_FETCHES; i++) begin
			r = take_bits(pc_lfsr, 22) << 2;
			if (take_bits(pc_lfsr, 3) == 0) begin
				run_fetch(r);
			end else begin
				run_fetch(`SDRAM_BASE + r);
			end
		end
		end_test(3'd6);
		@(negedge clock);

		$display("Summary: 6 tests, %0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+verilog
verilog/fetch_pkg.sv
verilog/icache_port_if.sv
verilog/burst_counter.sv
verilog/icache_array.sv
verilog/fetch_control.sv
verilog/fetch_unit.sv
bench/fetch_checker.sv
bench/fetch_tb.sv

// ==== verilog/burst_counter.sv ====
`timescale 1ns/100ps
`default_nettype none

module burst_counter (
	input  wire                         clock,
	input  wire                         arst_n,
	input  wire                         load,
	input  wire fetch_pkg::beat_total_t total,
	input  wire                         step,
	output fetch_pkg::fetch_offset_t    index,
	output logic                        last
);
	import fetch_pkg::*;

	beat_total_t total_q;
	logic        spent;

	assign last = beat_total_t'(index) == total_q - 1'b1;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			index <= '0;
			total_q <= '0;
			spent <= 1'b0;
		end else if (load) begin
			index <= '0;
			total_q <= total;
			spent <= 1'b0;
		end else if (step) begin
			index <= index + 1'b1;
			if (last) begin
				spent <= 1'b1;
			end
		end
	end

	// Once the final beat is counted nothing more arrives before a reload.
	a_no_extra_beat: assert property (@(posedge clock) disable iff (!arst_n)
		spent && !load |-> !step);

endmodule

`default_nettype wire

// ==== verilog/fetch_control.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "fetch_settings.svh"

module fetch_control (
	input  wire                           clock,
	input  wire                           arst_n,
	input  wire                           fetch_start,
	input  wire [31:0]                    pc,
	output logic [31:0]                   inst,
	output logic                          inst_valid,
	output logic                          inst_error,
	output logic [31:0]                   araddr,
	output logic                          arvalid,
	input  wire                           arready,
	output logic [1:0]                    arburst,
	output logic [3:0]                    arlen,
	input  wire [31:0]                    rdata,
	input  wire [1:0]                     rresp,
	input  wire                           rvalid,
	icache_port_if.controller             cache,
	input  wire fetch_pkg::fetch_offset_t beat_count,
	input  wire                           beat_last,
	output logic                          beat_load,
	output fetch_pkg::beat_total_t        beat_total,
	output logic                          beat_step
);
	import fetch_pkg::*;

	fetch_state_t state;
	fetch_addr_t  pc_addr;
	fetch_addr_t  addr_q;
	fetch_addr_t  line_addr;
	logic         pc_cached;
	logic         cached_q;
	logic         err_q;
	logic         beat_err;
	logic         start;
	logic [31:0]  word_q;

	assign pc_addr = pc;
	assign start = fetch_start && state == IDLE;
	assign pc_cached = pc >= `SDRAM_BASE && pc < `SDRAM_LIMIT;

	always_comb begin
		line_addr = addr_q;
		line_addr.field.offset = '0;
		line_addr.field.byte_sel = '0;
	end

	// Cached misses fetch the aligned line, uncached reads the exact word.
	assign arvalid = state == REQUEST;
	assign araddr = cached_q ? line_addr.flat : addr_q.flat;
	assign arburst = cached_q ? 2'b01 : 2'b00;
	assign arlen = cached_q ? 4'(`LINE_WORDS - 1) : 4'd0;

	assign beat_load = arvalid && arready;
	assign beat_total = cached_q ? beat_total_t'(`LINE_WORDS) : beat_total_t'(1);
	assign beat_step = state == COLLECT && rvalid;
	assign beat_err = err_q || rresp[1];

	// Lookup goes out with the start strobe so the hit is known in LOOKUP.
	assign cache.lookup = start && pc_cached;
	assign cache.addr = state == IDLE ? pc_addr : addr_q;
	assign cache.fill_we = beat_step && cached_q;
	assign cache.fill_offset = beat_count;
	assign cache.fill_data = rdata;
	assign cache.fill_done = beat_step && beat_last && cached_q && !beat_err;
	assign cache.fill_abort = beat_step && beat_last && cached_q && beat_err;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
			cached_q <= 1'b0;
			err_q <= 1'b0;
			inst_valid <= 1'b0;
			inst_error <= 1'b0;
		end else begin
			inst_valid <= 1'b0;
			case (state)
				IDLE: begin
					if (start) begin
						cached_q <= pc_cached;
						err_q <= 1'b0;
						state <= pc_cached ? LOOKUP : REQUEST;
					end
				end
				LOOKUP: begin
					state <= cache.hit ? DONE : REQUEST;
				end
				REQUEST: begin
					if (arready) begin
						state <= COLLECT;
					end
				end
				COLLECT: begin
					if (beat_step) begin
						err_q <= beat_err;
						if (beat_last) begin
							state <= DONE;
						end
					end
				end
				DONE: begin
					inst_valid <= 1'b1;
					inst_error <= err_q;
					state <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	// The wanted word is the one at the PC offset, or the single uncached beat.
	always_ff @(posedge clock) begin
		if (start) begin
			addr_q <= pc_addr;
		end
		if (state == LOOKUP) begin
			word_q <= cache.rd_data;
		end else if (beat_step && (!cached_q || beat_count == addr_q.field.offset)) begin
			word_q <= rdata;
		end
		if (state == DONE) begin
			inst <= word_q;
		end
	end

	a_ar_stable: assert property (@(posedge clock) disable iff (!arst_n)
		arvalid && !arready |=> arvalid && $stable(araddr));

	a_valid_pulse: assert property (@(posedge clock) disable iff (!arst_n)
		inst_valid |=> !inst_valid);

	a_start_idle: assert property (@(posedge clock) disable iff (!arst_n)
		fetch_start |-> state == IDLE);

endmodule

`default_nettype wire

// ==== verilog/fetch_pkg.sv ====
`default_nettype none
`include "fetch_settings.svh"

package fetch_pkg;

	typedef logic [$clog2(`LINE_WORDS)-1:0] fetch_offset_t;
	typedef logic [$clog2(`ICACHE_LINES)-1:0] fetch_index_t;
	typedef logic [31-$clog2(`ICACHE_LINES)-$clog2(`LINE_WORDS)-2:0] fetch_tag_t;

	// Wide enough to hold a full line count of beats.
	typedef logic [$clog2(`LINE_WORDS):0] beat_total_t;

	typedef struct packed {
		fetch_tag_t    tag;
		fetch_index_t  index;
		fetch_offset_t offset;
		logic [1:0]    byte_sel;
	} fetch_fields_t;

	// One fetch address, seen as a bus address or as cache fields.
	typedef union packed {
		logic [31:0]   flat;
		fetch_fields_t field;
	} fetch_addr_t;

	typedef enum logic [2:0] {
		IDLE,
		LOOKUP,
		REQUEST,
		COLLECT,
		DONE
	} fetch_state_t;

endpackage

`default_nettype wire

// ==== verilog/fetch_settings.svh ====
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// Instruction cache geometry.
`define ICACHE_LINES 16
`define LINE_WORDS 4

// Cacheable SDRAM window, base inclusive and limit exclusive.
`define SDRAM_BASE 32'ha000_0000
`define SDRAM_LIMIT 32'ha200_0000

`endif

// ==== verilog/fetch_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_unit (
	input  wire        clock,
	input  wire        arst_n,

	input  wire        fetch_start,
	input  wire [31:0] pc,
	input  wire        invalidate,
	output wire [31:0] inst,
	output wire        inst_valid,
	output wire        inst_error,

	output wire [31:0] araddr,
	output wire        arvalid,
	input  wire        arready,
	output wire [1:0]  arburst,
	output wire [3:0]  arlen,
	input  wire [31:0] rdata,
	input  wire [1:0]  rresp,
	input  wire        rvalid
);
	import fetch_pkg::*;

	wire fetch_offset_t beat_index;
	wire beat_total_t   beat_total;
	wire                beat_last;
	wire                beat_load;
	wire                beat_step;

	icache_port_if cache_if ();

	fetch_control control_i (
		.clock       (clock),
		.arst_n      (arst_n),
		.fetch_start (fetch_start),
		.pc          (pc),
		.inst        (inst),
		.inst_valid  (inst_valid),
		.inst_error  (inst_error),
		.araddr      (araddr),
		.arvalid     (arvalid),
		.arready     (arready),
		.arburst     (arburst),
		.arlen       (arlen),
		.rdata       (rdata),
		.rresp       (rresp),
		.rvalid      (rvalid),
		.cache       (cache_if.controller),
		.beat_count  (beat_index),
		.beat_last   (beat_last),
		.beat_load   (beat_load),
		.beat_total  (beat_total),
		.beat_step   (beat_step)
	);

	burst_counter counter_i (
		.clock  (clock),
		.arst_n (arst_n),
		.load   (beat_load),
		.total  (beat_total),
		.step   (beat_step),
		.index  (beat_index),
		.last   (beat_last)
	);

	icache_array array_i (
		.clock      (clock),
		.arst_n     (arst_n),
		.invalidate (invalidate),
		.port       (cache_if.array)
	);

endmodule

`default_nettype wire

// ==== verilog/icache_array.sv ====
`timescale 1ns/100ps
`default_nettype none
`include "fetch_settings.svh"

module icache_array (
	input  wire          clock,
	input  wire          arst_n,
	input  wire          invalidate,
	icache_port_if.array port
);
	import fetch_pkg::*;

	logic [31:0]              data_mem [`ICACHE_LINES][`LINE_WORDS];
	fetch_tag_t               tag_mem [`ICACHE_LINES];
	logic [`ICACHE_LINES-1:0] valid_q;
	logic                     hit_q;
	logic [31:0]              rd_q;
	fetch_index_t             index;
	fetch_offset_t            offset;
	fetch_tag_t               tag;

	assign index = port.addr.field.index;
	assign offset = port.addr.field.offset;
	assign tag = port.addr.field.tag;

	assign port.hit = hit_q;
	assign port.rd_data = rd_q;

	always_ff @(posedge clock) begin
		if (port.fill_we) begin
			data_mem[index][port.fill_offset] <= port.fill_data;
		end
		if (port.fill_done) begin
			tag_mem[index] <= tag;
		end
		if (port.lookup) begin
			rd_q <= data_mem[index][offset];
		end
	end

	// A fence in the same cycle wins over the lookup.
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			valid_q <= '0;
			hit_q <= 1'b0;
		end else begin
			if (port.lookup) begin
				hit_q <= !invalidate && valid_q[index] && tag_mem[index] == tag;
			end
			if (invalidate) begin
				valid_q <= '0;
			end else if (port.fill_done) begin
				valid_q[index] <= 1'b1;
			end else if (port.fill_abort) begin
				valid_q[index] <= 1'b0;
			end
		end
	end

	a_fill_end: assert property (@(posedge clock) disable iff (!arst_n)
		!(port.fill_done && port.fill_abort));

endmodule

`default_nettype wire

// ==== verilog/icache_port_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface icache_port_if;
	import fetch_pkg::*;

	logic          lookup;
	fetch_addr_t   addr;
	logic          fill_we;
	fetch_offset_t fill_offset;
	logic [31:0]   fill_data;
	logic          fill_done;
	logic          fill_abort;

	// Valid in the cycle after a lookup.
	logic          hit;
	logic [31:0]   rd_data;

	modport controller (
		output lookup,
		output addr,
		output fill_we,
		output fill_offset,
		output fill_data,
		output fill_done,
		output fill_abort,
		input  hit,
		input  rd_data
	);

	modport array (
		input  lookup,
		input  addr,
		input  fill_we,
		input  fill_offset,
		input  fill_data,
		input  fill_done,
		input  fill_abort,
		output hit,
		output rd_data
	);

endinterface

`default_nettype wire
